// ==== flist.f ====
dcache_pkg.sv
dcache.sv
miss_queue.sv
write_buffer.sv
main_memory.sv
dcache_top.sv
dcache_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the dcache testbench, fail when the log reports errors
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 -f flist.f --top-module dcache_tb -o dcache_sim
./obj_dir/dcache_sim | tee sim.log
if grep -q "Done: errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
exit 0

// ==== dcache_tb.sv ====
/* testbench for the data cache subsystem: reference byte memory,
   load and store drivers, directed tests and a random mix */
`timescale 1ns/100ps
`default_nettype none

module dcache_tb import dcache_pkg::*; ();
    localparam int LSQ = 8;
    localparam int LAT = 3;
    localparam int TIMEOUT = 200;

    logic           clock = 1'b0;
    logic           reset;
    logic           ld_valid, ld_ready, st_valid, st_ready;
    addr_t          ld_addr, st_addr;
    mem_size_t      ld_size, st_size;
    logic [LSQ-1:0] ld_gnt, hit_gnt, miss_gnt;
    dword_t         st_data, hit_data, miss_data;
    logic           hit_valid, miss_valid;

    // architectural byte values starting from zero
    logic [7:0]     model [65536] = '{default: 8'h00};
    int             miss_loads = 0;
    int             miss_responses = 0;

    dcache_top #(.LSQ_SIZE(LSQ), .MEM_LATENCY(LAT)) uut (.*);

    always #2 clock = ~clock;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input dword_t got, input dword_t exp);
        assert (got === exp)
            else fail_run($sformatf("mismatch %s: got %h expected %h", name, got, exp));
    endtask

    // little endian and right-aligned
    function automatic dword_t expected_bytes(input addr_t a, input mem_size_t sz);
        dword_t r;
        r = '0;
        for (int i = 0; i < (1 << sz); i++)
            r = r | (dword_t'(model[a + addr_t'(i)]) << (8 * i));
        return r;
    endfunction

    function automatic void update_model(input addr_t a, input mem_size_t sz, input dword_t d);
        for (int i = 0; i < (1 << sz); i++)
            model[a + addr_t'(i)] = 8'(d >> (8 * i));
    endfunction

    // each miss response needs a load that missed
    always @(negedge clock) begin
        if (!reset && miss_valid) begin
            assert (miss_responses < miss_loads)
                else fail_run("miss response without an outstanding load miss");
            miss_responses++;
        end
    end

    task automatic send_store(input addr_t a, input mem_size_t sz, input dword_t d);
        int t;
        st_valid = 1'b1;
        st_addr = a;
        st_size = sz;
        st_data = d;
        t = 0;
        forever begin
            #1;
            if (st_ready)
                break;
            @(negedge clock);
            t++;
            assert (t < TIMEOUT) else fail_run("timeout waiting for st_ready");
        end
        update_model(a, sz, d);
        @(negedge clock);
        st_valid = 1'b0;
    endtask

    task automatic load_and_check(input addr_t a, input mem_size_t sz, output logic hit);
        dword_t         exp;
        logic [LSQ-1:0] gnt;
        int             t;
        gnt = LSQ'(1) << ($urandom % LSQ);
        ld_valid = 1'b1;
        ld_addr = a;
        ld_size = sz;
        ld_gnt = gnt;
        t = 0;
        forever begin
            #1;
            if (ld_ready)
                break;
            @(negedge clock);
            t++;
            assert (t < TIMEOUT) else fail_run("timeout waiting for ld_ready");
        end
        exp = expected_bytes(a, sz);
        hit = hit_valid;
        if (hit) begin
            check_value("hit_data", hit_data, exp);
            check_value("hit_gnt", dword_t'(hit_gnt), dword_t'(gnt));
        end else begin
            miss_loads++;
        end
        @(negedge clock);
        ld_valid = 1'b0;
        if (!hit) begin
            t = 0;
            while (!miss_valid) begin
                @(negedge clock);
                t++;
                assert (t < TIMEOUT) else fail_run("timeout waiting for miss_valid");
            end
            check_value("miss_data", miss_data, exp);
            check_value("miss_gnt", dword_t'(miss_gnt), dword_t'(gnt));
            // fill is written at the end of the response cycle
            @(negedge clock);
        end
    endtask

    task automatic load_expecting(input addr_t a, input mem_size_t sz, input logic want_hit);
        logic hit;
        load_and_check(a, sz, hit);
        if (want_hit) begin
            assert (hit) else fail_run("load expected to hit was answered on the miss port");
        end else begin
            assert (!hit) else fail_run("load expected to miss was answered on the hit port");
        end
    endtask

    task automatic store_miss_then_load();
        send_store(16'h1208, DOUBLE, 64'h0123_4567_89ab_cdef);
        load_expecting(16'h1208, DOUBLE, 1'b0);
    endtask

    task automatic sized_hits();
        load_expecting(16'h1208, BYTE, 1'b1);
        load_expecting(16'h120b, BYTE, 1'b1);
        load_expecting(16'h120f, BYTE, 1'b1);
        load_expecting(16'h120a, HALF, 1'b1);
        load_expecting(16'h120e, HALF, 1'b1);
        load_expecting(16'h1208, WORD, 1'b1);
        load_expecting(16'h120c, WORD, 1'b1);
    endtask

    task automatic store_hit_merge();
        send_store(16'h1209, BYTE, 64'hffff_ffff_ffff_ff5a);
        send_store(16'h120c, HALF, 64'h0000_0000_0000_c3d2);
        load_expecting(16'h1208, DOUBLE, 1'b1);
    endtask

    // three tags on index 2
    task automatic victim_swap();
        send_store(16'h2110, DOUBLE, {$urandom, $urandom});
        send_store(16'h2210, DOUBLE, {$urandom, $urandom});
        send_store(16'h2310, DOUBLE, {$urandom, $urandom});
        load_expecting(16'h2110, DOUBLE, 1'b0);
        load_expecting(16'h2210, DOUBLE, 1'b0);
        load_expecting(16'h2310, DOUBLE, 1'b0);
        load_expecting(16'h2210, DOUBLE, 1'b1);
        load_expecting(16'h2110, WORD, 1'b1);
    endtask

    task automatic dirty_writeback();
        send_store(16'h3118, DOUBLE, {$urandom, $urandom});
        load_expecting(16'h3118, DOUBLE, 1'b0);
        send_store(16'h3118, DOUBLE, {$urandom, $urandom});
        send_store(16'h311a, HALF, {$urandom, $urandom});
        // four more fills on index 3 push the dirty line out of the victim buffer
        for (int i = 2; i < 6; i++)
            load_expecting({line_tag_t'(8'h30 + i), line_idx_t'(3), line_off_t'(0)}, DOUBLE, 1'b0);
        load_expecting(16'h3118, DOUBLE, 1'b0);
    endtask

    task automatic random_mix();
        addr_t     a;
        mem_size_t sz;
        logic      hit;
        int        hits;
        hits = 0;
        for (int n = 0; n < 200; n++) begin
            sz = mem_size_t'(2'($urandom % 4));
            a = {line_tag_t'(8'h40 + $urandom % 4), line_idx_t'(4 + $urandom % 4),
                 line_off_t'(($urandom % 8) & ~((1 << sz) - 1))};
            if ($urandom % 2 == 0) begin
                send_store(a, sz, {$urandom, $urandom});
            end else begin
                load_and_check(a, sz, hit);
                hits += int'(hit);
            end
        end
        // idle tail lets a late duplicate response show up
        repeat (4 * LAT) @(negedge clock);
        $display("random mix: %0d loads answered on the hit port", hits);
    endtask

    initial begin
        void'($urandom(69));
        reset = 1'b1;
        ld_valid = 1'b0;
        ld_addr = '0;
        ld_size = BYTE;
        ld_gnt = '0;
        st_valid = 1'b0;
        st_addr = '0;
        st_size = BYTE;
        st_data = '0;
        repeat (3) @(negedge clock);
        reset = 1'b0;
        store_miss_then_load();
        sized_hits();
        store_hit_merge();
        victim_swap();
        dirty_writeback();
        random_mix();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dcache_top.sv ====
/* data cache subsystem top: cache, miss queue, write buffer, memory */
`timescale 1ns/100ps
`default_nettype none

module dcache_top import dcache_pkg::*; #(
    parameter int LSQ_SIZE    = 8,
    parameter int MISS_DEPTH  = 4,
    parameter int WBUF_DEPTH  = 4,
    parameter int MEM_LATENCY = 3
) (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 ld_valid,
    input  wire addr_t          ld_addr,
    input  wire mem_size_t      ld_size,
    input  wire [LSQ_SIZE-1:0]  ld_gnt,
    output logic                ld_ready,
    input  wire                 st_valid,
    input  wire addr_t          st_addr,
    input  wire mem_size_t      st_size,
    input  wire dword_t         st_data,
    output logic                st_ready,
    output logic                hit_valid,
    output dword_t              hit_data,
    output logic [LSQ_SIZE-1:0] hit_gnt,
    output logic                miss_valid,
    output dword_t              miss_data,
    output logic [LSQ_SIZE-1:0] miss_gnt
);
    logic      ld_en, st_en, rd_miss_en, wr_miss_en, wb_en, fill_en;
    addr_t     wr_miss_addr, wb_addr, mem_rd_addr, wbuf_addr;
    dword_t    wr_miss_data, wb_data, fill_data, mem_rd_rsp_data, wbuf_data;
    mem_size_t wr_miss_size, wbuf_size;
    line_idx_t fill_idx;
    line_tag_t fill_tag;
    logic      mq_empty, wbuf_empty, two_free, wbuf_valid, wbuf_ready;
    logic      mem_rd_valid, mem_rd_ready, mem_rd_rsp_valid;

    assign ld_en = ld_valid && ld_ready;
    // no stores while a load miss is outstanding
    assign st_ready = mq_empty && two_free;
    assign st_en = st_valid && st_ready;

    dcache #(.LSQ_SIZE(LSQ_SIZE)) u_dcache (
        .clock, .reset, .ld_en, .ld_addr, .ld_size, .ld_gnt,
        .st_en, .st_addr, .st_size, .st_data,
        .fill_en, .fill_idx, .fill_tag, .fill_data,
        .hit_valid, .hit_data, .hit_gnt, .rd_miss_en,
        .wr_miss_en, .wr_miss_addr, .wr_miss_data, .wr_miss_size,
        .wb_en, .wb_addr, .wb_data
    );

    miss_queue #(.LSQ_SIZE(LSQ_SIZE), .MISS_DEPTH(MISS_DEPTH)) u_miss_queue (
        .clock, .reset,
        .push(rd_miss_en), .push_addr(ld_addr), .push_size(ld_size), .push_gnt(ld_gnt),
        .wbuf_empty, .mem_rd_ready, .mem_rd_rsp_valid, .mem_rd_rsp_data,
        .has_space(ld_ready), .is_empty(mq_empty), .mem_rd_valid, .mem_rd_addr,
        .fill_en, .fill_idx, .fill_tag, .fill_data,
        .miss_valid, .miss_data, .miss_gnt
    );

    write_buffer #(.WBUF_DEPTH(WBUF_DEPTH)) u_write_buffer (
        .clock, .reset,
        .st_push(wr_miss_en), .st_addr(wr_miss_addr), .st_data(wr_miss_data),
        .st_size(wr_miss_size), .wb_push(wb_en), .wb_addr, .wb_data,
        .pop_ready(wbuf_ready), .two_free, .is_empty(wbuf_empty),
        .wbuf_valid, .wbuf_addr, .wbuf_data, .wbuf_size
    );

    main_memory #(.MEM_LATENCY(MEM_LATENCY)) u_main_memory (
        .clock, .reset,
        .wr_valid(wbuf_valid), .wr_addr(wbuf_addr), .wr_data(wbuf_data), .wr_size(wbuf_size),
        .rd_valid(mem_rd_valid), .rd_addr(mem_rd_addr),
        .wr_ready(wbuf_ready), .rd_ready(mem_rd_ready),
        .rd_rsp_valid(mem_rd_rsp_valid), .rd_rsp_data(mem_rd_rsp_data)
    );

endmodule

`default_nettype wire

// ==== main_memory.sv ====
/* 8192-doubleword backing store with sized writes
   and a fixed-latency read pipeline */
`timescale 1ns/100ps
`default_nettype none

module main_memory import dcache_pkg::*; #(
    parameter int MEM_LATENCY = 3
) (
    input  wire            clock,
    input  wire            reset,
    input  wire            wr_valid,
    input  wire addr_t     wr_addr,
    input  wire dword_t    wr_data,
    input  wire mem_size_t wr_size,
    input  wire            rd_valid,
    input  wire addr_t     rd_addr,
    output logic           wr_ready,
    output logic           rd_ready,
    output logic           rd_rsp_valid,
    output dword_t         rd_rsp_data
);
    localparam int WORDS = 8192;

    dword_t                 mem [WORDS] = '{default: '0};
    logic [MEM_LATENCY-1:0] vld_pipe;
    dword_t                 data_pipe [MEM_LATENCY];
    logic                   rd_fire;
    logic [5:0]             wr_shift;
    dword_t                 wr_mask;

    // writes win, a read waits one cycle
    assign wr_ready = 1'b1;
    assign rd_ready = !wr_valid;
    assign rd_fire = rd_valid && rd_ready;
    assign wr_shift = {wr_addr[2:0], 3'b000};
    assign wr_mask = size_mask(wr_size) << wr_shift;
    assign rd_rsp_valid = vld_pipe[MEM_LATENCY-1];
    assign rd_rsp_data = data_pipe[MEM_LATENCY-1];

    always_ff @(posedge clock) begin
        if (wr_valid && wr_ready)
            mem[wr_addr[15:3]] <= (mem[wr_addr[15:3]] & ~wr_mask) |
                                  ((wr_data << wr_shift) & wr_mask);
    end

    always_ff @(posedge clock) begin
        if (reset)
            vld_pipe <= '0;
        else
            vld_pipe <= MEM_LATENCY'({vld_pipe, rd_fire});
    end

    // data is taken at acceptance, later writes do not reach it
    always_ff @(posedge clock) begin
        data_pipe[0] <= mem[rd_addr[15:3]];
        for (int i = 1; i < MEM_LATENCY; i++)
            data_pipe[i] <= data_pipe[i-1];
    end

endmodule

`default_nettype wire

// ==== write_buffer.sv ====
/* FIFO of pending memory writes, two pushes and one pop per cycle */
`timescale 1ns/100ps
`default_nettype none

module write_buffer import dcache_pkg::*; #(
    parameter int WBUF_DEPTH = 4
) (
    input  wire            clock,
    input  wire            reset,
    input  wire            st_push,
    input  wire addr_t     st_addr,
    input  wire dword_t    st_data,
    input  wire mem_size_t st_size,
    input  wire            wb_push,
    input  wire addr_t     wb_addr,
    input  wire dword_t    wb_data,
    input  wire            pop_ready,
    output logic           two_free,
    output logic           is_empty,
    output logic           wbuf_valid,
    output addr_t          wbuf_addr,
    output dword_t         wbuf_data,
    output mem_size_t      wbuf_size
);
    // power-of-two depth
    localparam int PW = $clog2(WBUF_DEPTH);
    localparam int CW = $clog2(WBUF_DEPTH + 1);

    addr_t         b_addr [WBUF_DEPTH];
    dword_t        b_data [WBUF_DEPTH];
    mem_size_t     b_size [WBUF_DEPTH];
    logic [PW-1:0] wr_ptr, wb_ptr, rd_ptr;
    logic [CW-1:0] count, count_n;
    logic          pop;

    // store miss takes the first slot
    assign wb_ptr = st_push ? wr_ptr + 1'b1 : wr_ptr;
    assign pop = wbuf_valid && pop_ready;
    assign count_n = count + CW'(st_push) + CW'(wb_push) - CW'(pop);
    assign is_empty = (count == '0);
    assign wbuf_valid = !is_empty;
    assign wbuf_addr = b_addr[rd_ptr];
    assign wbuf_data = b_data[rd_ptr];
    assign wbuf_size = b_size[rd_ptr];

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            two_free <= 1'b0;
        end else begin
            wr_ptr <= wr_ptr + PW'(st_push) + PW'(wb_push);
            rd_ptr <= rd_ptr + PW'(pop);
            count <= count_n;
            two_free <= (count_n <= CW'(WBUF_DEPTH - 2));
        end
    end

    always_ff @(posedge clock) begin
        if (st_push) begin
            b_addr[wr_ptr] <= st_addr;
            b_data[wr_ptr] <= st_data;
            b_size[wr_ptr] <= st_size;
        end
        if (wb_push) begin
            b_addr[wb_ptr] <= wb_addr;
            b_data[wb_ptr] <= wb_data;
            b_size[wb_ptr] <= DOUBLE;
        end
    end

endmodule

`default_nettype wire

// ==== miss_queue.sv ====
/* FIFO of outstanding load misses, memory read issue,
   cache fill and miss response */
`timescale 1ns/100ps
`default_nettype none

module miss_queue import dcache_pkg::*; #(
    parameter int LSQ_SIZE   = 8,
    parameter int MISS_DEPTH = 4
) (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 push,
    input  wire addr_t          push_addr,
    input  wire mem_size_t      push_size,
    input  wire [LSQ_SIZE-1:0]  push_gnt,
    input  wire                 wbuf_empty,
    input  wire                 mem_rd_ready,
    input  wire                 mem_rd_rsp_valid,
    input  wire dword_t         mem_rd_rsp_data,
    output logic                has_space,
    output logic                is_empty,
    output logic                mem_rd_valid,
    output addr_t               mem_rd_addr,
    output logic                fill_en,
    output line_idx_t           fill_idx,
    output line_tag_t           fill_tag,
    output dword_t              fill_data,
    output logic                miss_valid,
    output dword_t              miss_data,
    output logic [LSQ_SIZE-1:0] miss_gnt
);
    // depth is a power of two, pointers wrap on their own
    localparam int PW = $clog2(MISS_DEPTH);
    localparam int CW = $clog2(MISS_DEPTH + 1);

    addr_t               q_addr [MISS_DEPTH];
    mem_size_t           q_size [MISS_DEPTH];
    logic [LSQ_SIZE-1:0] q_gnt [MISS_DEPTH];
    logic [PW-1:0]       wr_ptr, iss_ptr, ret_ptr;
    logic [CW-1:0]       count, count_n, unissued;
    logic                issue;
    line_off_t           ret_off;

    // reads wait for the write buffer to drain
    assign mem_rd_valid = (unissued != '0) && wbuf_empty;
    assign mem_rd_addr = q_addr[iss_ptr];
    assign issue = mem_rd_valid && mem_rd_ready;
    assign is_empty = (count == '0);
    assign count_n = count + CW'(push) - CW'(mem_rd_rsp_valid);

    // replies return in issue order, so the head owns them
    assign {fill_tag, fill_idx, ret_off} = q_addr[ret_ptr];
    assign fill_en = mem_rd_rsp_valid;
    assign fill_data = mem_rd_rsp_data;
    assign miss_valid = mem_rd_rsp_valid;
    assign miss_data = (mem_rd_rsp_data >> {ret_off, 3'b0}) & size_mask(q_size[ret_ptr]);
    assign miss_gnt = q_gnt[ret_ptr];

    always_ff @(posedge clock) begin
        if (reset) begin
            wr_ptr <= '0;
            iss_ptr <= '0;
            ret_ptr <= '0;
            count <= '0;
            unissued <= '0;
            has_space <= 1'b0;
        end else begin
            wr_ptr <= wr_ptr + PW'(push);
            iss_ptr <= iss_ptr + PW'(issue);
            ret_ptr <= ret_ptr + PW'(mem_rd_rsp_valid);
            count <= count_n;
            unissued <= unissued + CW'(push) - CW'(issue);
            has_space <= (count_n < CW'(MISS_DEPTH));
        end
    end

    always_ff @(posedge clock) begin
        if (push) begin
            q_addr[wr_ptr] <= push_addr;
            q_size[wr_ptr] <= push_size;
            q_gnt[wr_ptr] <= push_gnt;
        end
    end

endmodule

`default_nettype wire

// ==== dcache.sv ====
/* direct-mapped 32 x 64-bit data cache with a two-entry victim buffer
   store, load and fill stages feed one register stage */
`timescale 1ns/100ps
`default_nettype none

module dcache import dcache_pkg::*; #(
    parameter int LSQ_SIZE = 8
) (
    input  wire                 clock,
    input  wire                 reset,
    input  wire                 ld_en,
    input  wire addr_t          ld_addr,
    input  wire mem_size_t      ld_size,
    input  wire [LSQ_SIZE-1:0]  ld_gnt,
    input  wire                 st_en,
    input  wire addr_t          st_addr,
    input  wire mem_size_t      st_size,
    input  wire dword_t         st_data,
    input  wire                 fill_en,
    input  wire line_idx_t      fill_idx,
    input  wire line_tag_t      fill_tag,
    input  wire dword_t         fill_data,
    output logic                hit_valid,
    output dword_t              hit_data,
    output logic [LSQ_SIZE-1:0] hit_gnt,
    output logic                rd_miss_en,
    output logic                wr_miss_en,
    output addr_t               wr_miss_addr,
    output dword_t              wr_miss_data,
    output mem_size_t           wr_miss_size,
    output logic                wb_en,
    output addr_t               wb_addr,
    output dword_t              wb_data
);
    localparam int LINES = 32;

    line_tag_t ld_tag, st_tag;
    line_idx_t ld_idx, st_idx;
    line_off_t ld_off, st_off;
    dword_t    ld_mask, st_mask, st_shifted;

    dword_t           data [LINES];
    dword_t           data_n [LINES];
    line_tag_t        tags [LINES];
    line_tag_t        tags_n [LINES];
    logic [LINES-1:0] valid, valid_n, dirty, dirty_n;
    victim_tag_t      v_tag [2];
    victim_tag_t      v_tag_n [2];
    dword_t           v_data [2];
    dword_t           v_data_n [2];
    logic [1:0]       v_valid, v_valid_n, v_dirty, v_dirty_n;
    // victim entry to replace next
    logic             lru, lru_n;

    assign {st_tag, st_idx, st_off} = st_addr;
    assign {ld_tag, ld_idx, ld_off} = ld_addr;
    assign st_mask = size_mask(st_size) << {st_off, 3'b0};
    assign st_shifted = st_data << {st_off, 3'b0};
    assign ld_mask = size_mask(ld_size);

    always_comb begin
        logic [1:0] vmatch;
        logic       vsel;
        dword_t     tmp_data;
        line_tag_t  tmp_tag;
        logic       tmp_dirty;

        data_n = data;
        tags_n = tags;
        valid_n = valid;
        dirty_n = dirty;
        v_tag_n = v_tag;
        v_data_n = v_data;
        v_valid_n = v_valid;
        v_dirty_n = v_dirty;
        lru_n = lru;
        hit_valid = 1'b0;
        hit_data = '0;
        hit_gnt = '0;
        rd_miss_en = 1'b0;
        wr_miss_en = 1'b0;
        wr_miss_addr = '0;
        wr_miss_data = '0;
        wr_miss_size = BYTE;
        wb_en = 1'b0;
        wb_addr = '0;
        wb_data = '0;
        tmp_data = '0;
        tmp_tag = '0;
        tmp_dirty = 1'b0;

        // store stage
        for (int i = 0; i < 2; i++)
            vmatch[i] = v_valid[i] && v_tag[i] == {st_tag, st_idx};
        vsel = vmatch[1];
        if (st_en) begin
            if (valid[st_idx] && tags[st_idx] == st_tag) begin
                data_n[st_idx] = (data[st_idx] & ~st_mask) | (st_shifted & st_mask);
                dirty_n[st_idx] = 1'b1;
            end else if (vmatch != 2'b00) begin
                // array line drops into the victim slot, merged victim line moves up
                v_tag_n[vsel] = {tags[st_idx], st_idx};
                v_data_n[vsel] = data[st_idx];
                v_valid_n[vsel] = valid[st_idx];
                v_dirty_n[vsel] = dirty[st_idx];
                data_n[st_idx] = (v_data[vsel] & ~st_mask) | (st_shifted & st_mask);
                tags_n[st_idx] = v_tag[vsel][12:5];
                valid_n[st_idx] = 1'b1;
                dirty_n[st_idx] = 1'b1;
                lru_n = ~vsel;
            end else begin
                wr_miss_en = 1'b1;
                wr_miss_addr = st_addr;
                wr_miss_data = st_data;
                wr_miss_size = st_size;
            end
        end

        // load stage, sees the store result
        for (int i = 0; i < 2; i++)
            vmatch[i] = v_valid_n[i] && v_tag_n[i] == {ld_tag, ld_idx};
        vsel = vmatch[1];
        if (ld_en) begin
            if (valid_n[ld_idx] && tags_n[ld_idx] == ld_tag) begin
                hit_valid = 1'b1;
                hit_data = (data_n[ld_idx] >> {ld_off, 3'b0}) & ld_mask;
                hit_gnt = ld_gnt;
            end else if (vmatch != 2'b00) begin
                tmp_data = v_data_n[vsel];
                tmp_tag = v_tag_n[vsel][12:5];
                tmp_dirty = v_dirty_n[vsel];
                hit_valid = 1'b1;
                hit_data = (tmp_data >> {ld_off, 3'b0}) & ld_mask;
                hit_gnt = ld_gnt;
                v_tag_n[vsel] = {tags_n[ld_idx], ld_idx};
                v_data_n[vsel] = data_n[ld_idx];
                v_valid_n[vsel] = valid_n[ld_idx];
                v_dirty_n[vsel] = dirty_n[ld_idx];
                data_n[ld_idx] = tmp_data;
                tags_n[ld_idx] = tmp_tag;
                valid_n[ld_idx] = 1'b1;
                dirty_n[ld_idx] = tmp_dirty;
                lru_n = ~vsel;
            end else begin
                rd_miss_en = 1'b1;
            end
        end

        // fill stage, last
        for (int i = 0; i < 2; i++)
            vmatch[i] = v_valid_n[i] && v_tag_n[i] == {fill_tag, fill_idx};
        // lru entry first unless only the other one is free
        vsel = (v_valid_n[lru_n] && !v_valid_n[~lru_n]) ? ~lru_n : lru_n;
        if (fill_en && vmatch == 2'b00 &&
                !(valid_n[fill_idx] && tags_n[fill_idx] == fill_tag)) begin
            if (valid_n[fill_idx]) begin
                if (v_valid_n[vsel] && v_dirty_n[vsel]) begin
                    wb_en = 1'b1;
                    wb_addr = {v_tag_n[vsel], 3'b000};
                    wb_data = v_data_n[vsel];
                end
                v_tag_n[vsel] = {tags_n[fill_idx], fill_idx};
                v_data_n[vsel] = data_n[fill_idx];
                v_valid_n[vsel] = 1'b1;
                v_dirty_n[vsel] = dirty_n[fill_idx];
                lru_n = ~vsel;
            end
            data_n[fill_idx] = fill_data;
            tags_n[fill_idx] = fill_tag;
            valid_n[fill_idx] = 1'b1;
            dirty_n[fill_idx] = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
            v_valid <= '0;
            v_dirty <= '0;
            lru <= 1'b0;
        end else begin
            valid <= valid_n;
            dirty <= dirty_n;
            v_valid <= v_valid_n;
            v_dirty <= v_dirty_n;
            lru <= lru_n;
        end
    end

    always_ff @(posedge clock) begin
        data <= data_n;
        tags <= tags_n;
        v_tag <= v_tag_n;
        v_data <= v_data_n;
    end

endmodule

`default_nettype wire

// ==== dcache_pkg.sv ====
/* access size enum, address field types and the size mask
   shared by the cache, miss queue, write buffer and memory */
`default_nettype none

package dcache_pkg;

    typedef enum logic [1:0] {
        BYTE   = 2'd0,
        HALF   = 2'd1,
        WORD   = 2'd2,
        DOUBLE = 2'd3
    } mem_size_t;

    typedef logic [15:0] addr_t;
    typedef logic [63:0] dword_t;
    typedef logic [2:0]  line_off_t;
    typedef logic [4:0]  line_idx_t;
    typedef logic [7:0]  line_tag_t;
    // tag above index
    typedef logic [12:0] victim_tag_t;

    // right-aligned mask covering the bytes of one access
    function automatic dword_t size_mask(input mem_size_t size);
        case (size)
            BYTE:    return 64'h0000_0000_0000_00ff;
            HALF:    return 64'h0000_0000_0000_ffff;
            WORD:    return 64'h0000_0000_ffff_ffff;
            default: return '1;
        endcase
    endfunction

endpackage

`default_nettype wire
